// ==== design/bank_pkg.sv ====
package bank_pkg;

    localparam int ROW_W  = 14;                 // row address bits
    localparam int COL_W  = 10;                 // column address bits
    localparam int ID_W   = 4;                  // transaction id bits
    localparam int LEN_W  = 4;                  // burst length field bits
    localparam int TCNT_W = 5;                  // widest timing value is 16

    typedef logic [ROW_W-1:0]  row_addr_t;
    typedef logic [COL_W-1:0]  col_addr_t;
    typedef logic [ID_W-1:0]   txn_id_t;
    typedef logic [LEN_W-1:0]  burst_len_t;
    typedef logic [TCNT_W-1:0] tcnt_t;

    typedef enum logic [2:0] {
        IDLE,                                   // row closed, rc may still run
        ACTIVATING,                             // waiting for rcd
        BANK_ACTIVE,                            // row open, ready for access
        READING,                                // read burst in flight
        WRITING,                                // write burst in flight
        PRECHARGING,                            // waiting for rp
        REFRESHING                              // waiting for rfc
    } bank_state_e;

    typedef enum logic [2:0] {
        CLS_NONE,                               // no valid request
        CLS_CLOSED,                             // valid, bank has no open row
        CLS_HIT_RD,                             // open row matches, read
        CLS_HIT_WR,                             // open row matches, write
        CLS_MISS                                // open row differs
    } req_class_e;

    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        txn_id_t    id;
        burst_len_t len;
        logic       wr;                         // 1 = write, 0 = read
    } bank_req_t;

    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        txn_id_t    id;
        burst_len_t len;
    } bank_cmd_t;

    // one flag per timer, true once its window has passed
    typedef struct packed {
        logic rc;
        logic ras;
        logic rcd;
        logic rp;
        logic rtp;
        logic wtp;
        logic burst;
        logic rfc;
        logic row_idle;
    } timing_met_t;

    localparam int NUM_TIMERS = $bits(timing_met_t);

    // cycles from the starting grant until the flag is set
    localparam tcnt_t T_RCD      = 5'd3;        // act to rd/wr
    localparam tcnt_t T_RAS      = 5'd8;        // act to pre
    localparam tcnt_t T_RC       = 5'd11;       // act to act
    localparam tcnt_t T_RP       = 5'd3;        // pre to act
    localparam tcnt_t T_RTP      = 5'd2;        // rd to pre
    localparam tcnt_t T_WTP      = 5'd6;        // wr to pre, includes write recovery
    localparam tcnt_t T_BURST    = 5'd4;        // data beats on the bus
    localparam tcnt_t T_RFC      = 5'd12;       // refresh cycle
    localparam tcnt_t T_ROW_IDLE = 16;          // unused open row closes after this

endpackage

// ==== design/bank_req_decode.sv ====
module bank_req_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bank_pkg::bank_req_t   req_i,            // held stable while valid
    input  logic                  req_valid_i,
    input  logic                  open_row_load_i,  // pulse on accepted activate
    input  logic                  row_close_i,      // pulse on accepted precharge
    output bank_pkg::req_class_e  req_class_o,
    output bank_pkg::row_addr_t   open_row_o
);
    import bank_pkg::*;

    row_addr_t open_row;                            // row latched at activate
    logic      row_open;                            // bank currently has a row open
    logic      row_match;                           // request targets the open row

    // open row flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_open <= 1'b0;
        end else if (open_row_load_i) begin
            row_open <= 1'b1;
        end else if (row_close_i) begin
            row_open <= 1'b0;
        end
    end

    // address of the open row, only meaningful while row_open
    always_ff @(posedge clk) begin
        if (open_row_load_i) begin
            open_row <= req_i.row;
        end
    end

    assign row_match = (req_i.row == open_row);

    // sort the pending request
    always_comb begin
        if (!req_valid_i) begin
            req_class_o = CLS_NONE;
        end else if (!row_open) begin
            req_class_o = CLS_CLOSED;               // needs an activate first
        end else if (row_match) begin
            req_class_o = req_i.wr ? CLS_HIT_WR : CLS_HIT_RD;
        end else begin
            req_class_o = CLS_MISS;                 // precharge, then activate
        end
    end

    assign open_row_o = open_row;

endmodule

// ==== design/bank_timers.sv ====
module bank_timers (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   act_gnt_i,
    input  logic                   rd_gnt_i,
    input  logic                   wr_gnt_i,
    input  logic                   pre_gnt_i,
    input  logic                   ref_gnt_i,
    output bank_pkg::timing_met_t  met_o
);
    import bank_pkg::*;

    timing_met_t                 start;             // load strobes, same layout as met_o
    logic [NUM_TIMERS-1:0]       start_vec;
    logic [NUM_TIMERS-1:0]       zero_vec;
    tcnt_t [NUM_TIMERS-1:0]      reload;            // load values, one per counter
    tcnt_t [NUM_TIMERS-1:0]      cnt;               // down-counters, zero = met

    // which grant starts which timer
    always_comb begin
        start          = '0;
        start.rc       = act_gnt_i;
        start.ras      = act_gnt_i;
        start.rcd      = act_gnt_i;
        start.rp       = pre_gnt_i;
        start.rtp      = rd_gnt_i;
        start.wtp      = wr_gnt_i;
        start.burst    = rd_gnt_i | wr_gnt_i;       // any column access
        start.rfc      = ref_gnt_i;
        start.row_idle = rd_gnt_i | wr_gnt_i;       // restarts on every access
    end

    assign start_vec = start;

    // counter loaded in the grant cycle reaches zero N cycles later,
    // so it starts one below N
    assign reload = {
        tcnt_t'(T_RC - 1'b1),
        tcnt_t'(T_RAS - 1'b1),
        tcnt_t'(T_RCD - 1'b1),
        tcnt_t'(T_RP - 1'b1),
        tcnt_t'(T_RTP - 1'b1),
        tcnt_t'(T_WTP - 1'b1),
        tcnt_t'(T_BURST - 1'b1),
        tcnt_t'(T_RFC - 1'b1),
        tcnt_t'(T_ROW_IDLE - 1'b1)
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;                              // all windows met after reset
        end else begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (start_vec[i]) begin
                    cnt[i] <= reload[i];            // grant restarts the window
                end else if (cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;        // saturate at zero
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            zero_vec[i] = (cnt[i] == '0);
        end
    end

    assign met_o = zero_vec;

endmodule

// ==== design/bank_fsm.sv ====
module bank_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bank_pkg::bank_req_t    req_i,
    input  bank_pkg::req_class_e   req_class_i,
    input  bank_pkg::row_addr_t    open_row_i,
    input  bank_pkg::timing_met_t  met_i,
    input  logic                   ref_req_i,       // level from refresh source
    input  logic                   act_gnt_i,
    input  logic                   rd_gnt_i,
    input  logic                   wr_gnt_i,
    input  logic                   pre_gnt_i,
    input  logic                   ref_gnt_i,
    output logic                   act_req_o,
    output logic                   rd_req_o,
    output logic                   wr_req_o,
    output logic                   pre_req_o,
    output logic                   ref_req_o,
    output bank_pkg::bank_cmd_t    cmd_o,
    output logic                   req_ready_o,
    output logic                   ref_gnt_o,
    output logic                   open_row_load_o,
    output logic                   row_close_o
);
    import bank_pkg::*;

    bank_state_e state;
    bank_state_e state_nxt;
    logic        req_valid;                         // some request pending
    logic        pre_ok;                            // row may close now
    logic        act_fire;
    logic        rd_fire;
    logic        wr_fire;
    logic        pre_fire;
    logic        ref_fire;

    assign req_valid = (req_class_i != CLS_NONE);
    assign pre_ok    = met_i.ras & met_i.rtp & met_i.wtp;

    // request levels toward the scheduler
    always_comb begin
        act_req_o = 1'b0;
        rd_req_o  = 1'b0;
        wr_req_o  = 1'b0;
        pre_req_o = 1'b0;
        ref_req_o = 1'b0;
        case (state)
            IDLE: begin
                ref_req_o = ref_req_i & met_i.rc;               // refresh wins
                act_req_o = req_valid & met_i.rc & ~ref_req_i;
            end
            BANK_ACTIVE: begin
                rd_req_o  = (req_class_i == CLS_HIT_RD);
                wr_req_o  = (req_class_i == CLS_HIT_WR);
                pre_req_o = pre_ok & ((req_class_i == CLS_MISS) |
                                      (~req_valid & met_i.row_idle));  // miss or idle row
            end
            default: ;                                          // waiting on a timer
        endcase
    end

    // a command is issued when its grant meets its request
    assign act_fire = act_req_o & act_gnt_i;
    assign rd_fire  = rd_req_o & rd_gnt_i;
    assign wr_fire  = wr_req_o & wr_gnt_i;
    assign pre_fire = pre_req_o & pre_gnt_i;
    assign ref_fire = ref_req_o & ref_gnt_i;

    always_comb begin
        state_nxt = state;                                      // hold without grant
        case (state)
            IDLE: begin
                if (ref_fire) begin
                    state_nxt = REFRESHING;
                end else if (act_fire) begin
                    state_nxt = ACTIVATING;
                end
            end
            ACTIVATING:  if (met_i.rcd) state_nxt = BANK_ACTIVE;
            BANK_ACTIVE: begin
                if (rd_fire) begin
                    state_nxt = READING;
                end else if (wr_fire) begin
                    state_nxt = WRITING;
                end else if (pre_fire) begin
                    state_nxt = PRECHARGING;
                end
            end
            READING:     if (met_i.burst) state_nxt = BANK_ACTIVE;
            WRITING:     if (met_i.burst) state_nxt = BANK_ACTIVE;
            PRECHARGING: if (met_i.rp) state_nxt = IDLE;
            REFRESHING:  if (met_i.rfc) state_nxt = IDLE;
            default:     state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // address fields that go with the raised request
    always_comb begin
        cmd_o = '0;
        if (act_req_o) begin
            cmd_o.row = req_i.row;                              // row to open
        end else if (pre_req_o) begin
            cmd_o.row = open_row_i;                             // row to close
        end else if (rd_req_o | wr_req_o) begin
            cmd_o.row = req_i.row;
            cmd_o.col = req_i.col;
            cmd_o.id  = req_i.id;
            cmd_o.len = req_i.len;
        end
    end

    assign req_ready_o     = rd_fire | wr_fire;                 // request consumed
    assign ref_gnt_o       = ref_fire;
    assign open_row_load_o = act_fire;
    assign row_close_o     = pre_fire;

    // scheduler must not grant what was not requested
    a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        ({act_gnt_i, rd_gnt_i, wr_gnt_i, pre_gnt_i, ref_gnt_i} &
         ~{act_req_o, rd_req_o, wr_req_o, pre_req_o, ref_req_o}) == '0);

    a_one_req_level: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({act_req_o, rd_req_o, wr_req_o, pre_req_o, ref_req_o}));

    // ready only with a pending request and for one cycle
    a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
        req_ready_o |-> req_valid ##1 !req_ready_o);

endmodule

// ==== design/bank_ctrl.sv ====
module bank_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bank_pkg::bank_req_t   req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output logic                  act_req_o,
    output logic                  rd_req_o,
    output logic                  wr_req_o,
    output logic                  pre_req_o,
    output logic                  ref_req_o,
    output bank_pkg::bank_cmd_t   cmd_o,
    input  logic                  act_gnt_i,
    input  logic                  rd_gnt_i,
    input  logic                  wr_gnt_i,
    input  logic                  pre_gnt_i,
    input  logic                  ref_gnt_i,
    input  logic                  ref_req_i,
    output logic                  ref_gnt_o
);
    import bank_pkg::*;

    req_class_e  req_class;                         // decoder verdict on pending request
    row_addr_t   open_row;
    timing_met_t met;
    logic        open_row_load;                     // activate accepted
    logic        row_close;                         // precharge accepted

    bank_req_decode bank_req_decode_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .open_row_load_i (open_row_load),
        .row_close_i     (row_close),
        .req_class_o     (req_class),
        .open_row_o      (open_row)
    );

    bank_timers bank_timers_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_gnt_i (act_gnt_i),
        .rd_gnt_i  (rd_gnt_i),
        .wr_gnt_i  (wr_gnt_i),
        .pre_gnt_i (pre_gnt_i),
        .ref_gnt_i (ref_gnt_i),
        .met_o     (met)
    );

    bank_fsm bank_fsm_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (req_i),
        .req_class_i     (req_class),
        .open_row_i      (open_row),
        .met_i           (met),
        .ref_req_i       (ref_req_i),
        .act_gnt_i       (act_gnt_i),
        .rd_gnt_i        (rd_gnt_i),
        .wr_gnt_i        (wr_gnt_i),
        .pre_gnt_i       (pre_gnt_i),
        .ref_gnt_i       (ref_gnt_i),
        .act_req_o       (act_req_o),
        .rd_req_o        (rd_req_o),
        .wr_req_o        (wr_req_o),
        .pre_req_o       (pre_req_o),
        .ref_req_o       (ref_req_o),
        .cmd_o           (cmd_o),
        .req_ready_o     (req_ready_o),
        .ref_gnt_o       (ref_gnt_o),
        .open_row_load_o (open_row_load),
        .row_close_o     (row_close)
    );

endmodule

// ==== bench/bank_ctrl_tb.sv ====
module bank_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import bank_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 16;
    localparam int BATCHES     = 4;
    localparam int BATCH_LEN   = 10;
    localparam int TOTAL_REQ   = BATCHES * BATCH_LEN + 3;    // batches, stall, two after refresh
    localparam int TIMEOUT_CYC = TOTAL_REQ * 200 + 2000;

    typedef enum logic [2:0] {K_NONE, K_ACT, K_RD, K_WR, K_PRE, K_REF} cmd_kind_e;

    typedef struct packed {
        cmd_kind_e kind;
        bank_cmd_t cmd;
        int        cyc;                                 // cycle the grant was taken
        logic      idle;                                // precharge with nothing pending
        logic      ready;                               // req_ready_o in that cycle
    } cmd_rec_t;

    typedef cmd_rec_t cmd_seq_t[$];

    logic        clk;
    logic        rst_n;
    bank_req_t   req_i;
    logic        req_valid_i;
    logic        req_ready_o;
    logic        act_req_o;
    logic        rd_req_o;
    logic        wr_req_o;
    logic        pre_req_o;
    logic        ref_req_o;
    bank_cmd_t   cmd_o;
    logic        act_gnt_i;
    logic        rd_gnt_i;
    logic        wr_gnt_i;
    logic        pre_gnt_i;
    logic        ref_gnt_i;
    logic        ref_req_i;
    logic        ref_gnt_o;

    bank_req_t   req_q[$];                              // requests waiting at the source
    cmd_rec_t    exp_q[$];                              // expected commands in order
    cmd_rec_t    log_q[$];                              // commands seen on the bus
    int unsigned delay_tab[256];                        // grant delays, 0 to 3 cycles
    int          delay_idx;
    int          cycle;
    int          sent;
    int          rdy_cnt;
    int          ref_cnt;
    int          idle_cnt;                              // rows closed by the idle timer
    int          val_errs;
    int          tim_errs;
    int          prot_errs;
    logic        req_done;                              // ready seen, drop valid next
    logic        ref_want;
    logic        hold_gnt;                              // scheduler stalls all grants
    logic        model_open;
    row_addr_t   model_row;
    cmd_kind_e   wait_kind;
    int          wait_left;
    event        logged;

    bank_ctrl bank_ctrl_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic cmd_kind_e level_kind();
        if (act_req_o) return K_ACT;
        if (rd_req_o) return K_RD;
        if (wr_req_o) return K_WR;
        if (pre_req_o) return K_PRE;
        if (ref_req_o) return K_REF;
        return K_NONE;
    endfunction

    function automatic cmd_kind_e issued_kind();
        if (act_req_o && act_gnt_i) return K_ACT;
        if (rd_req_o && rd_gnt_i) return K_RD;
        if (wr_req_o && wr_gnt_i) return K_WR;
        if (pre_req_o && pre_gnt_i) return K_PRE;
        if (ref_req_o && ref_gnt_i) return K_REF;
        return K_NONE;
    endfunction

    // closed row: act + access, hit: access, miss: pre + act + access
    function automatic cmd_seq_t expected_cmds(input logic row_open, input row_addr_t open_row,
                                               input bank_req_t r);
        cmd_seq_t seq;
        cmd_rec_t rec;
        rec = '0;
        if (row_open && open_row != r.row) begin
            rec.kind    = K_PRE;
            rec.cmd.row = open_row;                     // close the old row
            seq.push_back(rec);
        end
        if (!row_open || open_row != r.row) begin
            rec.kind    = K_ACT;
            rec.cmd     = '0;
            rec.cmd.row = r.row;
            seq.push_back(rec);
        end
        rec.kind    = r.wr ? K_WR : K_RD;
        rec.cmd.row = r.row;
        rec.cmd.col = r.col;
        rec.cmd.id  = r.id;
        rec.cmd.len = r.len;
        seq.push_back(rec);
        return seq;
    endfunction

    function automatic bank_req_t random_request();
        bank_req_t r;
        r.row = row_addr_t'(14'h0a0 + ($urandom % 3));  // three rows, many hits and misses
        r.col = col_addr_t'($urandom);
        r.id  = txn_id_t'($urandom);
        r.len = burst_len_t'($urandom);
        r.wr  = $urandom % 2;
        return r;
    endfunction

    task automatic check_kind(input string name, input cmd_kind_e exp, input cmd_kind_e act);
        if (act !== exp) begin
            val_errs++;
            $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_row(input string name, input row_addr_t exp, input row_addr_t act);
        if (act !== exp) begin
            val_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input bank_cmd_t exp, input bank_cmd_t act);
        if (act !== exp) begin
            val_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gap(input string rule, input int from_cyc, input int now_cyc,
                             input int min_gap);
        if (now_cyc - from_cyc < min_gap) begin
            tim_errs++;
            $display("timing error: %s only %0d cycles apart at cycle %0d, needs %0d",
                     rule, now_cyc - from_cyc, now_cyc, min_gap);
        end
    endtask

    task automatic drive_grant(input cmd_kind_e k);
        case (k)
            K_ACT:   act_gnt_i = 1'b1;
            K_RD:    rd_gnt_i  = 1'b1;
            K_WR:    wr_gnt_i  = 1'b1;
            K_PRE:   pre_gnt_i = 1'b1;
            default: ref_gnt_i = 1'b1;
        endcase
    endtask

    // request source, refresh source and scheduler model, all on the falling edge
    always @(negedge clk) begin
        logic      changed;                             // levels may move, no grant now
        cmd_kind_e lvl;
        cmd_seq_t  seq;
        changed = 1'b0;
        if (req_valid_i && req_done) begin
            req_valid_i = 1'b0;
            req_done    = 1'b0;
            changed     = 1'b1;
        end
        if (!req_valid_i && req_q.size() > 0) begin
            req_i = req_q.pop_front();
            seq   = expected_cmds(model_open, model_row, req_i);
            foreach (seq[i]) begin
                exp_q.push_back(seq[i]);
            end
            model_open  = 1'b1;                         // row left open after the access
            model_row   = req_i.row;
            req_valid_i = 1'b1;
            changed     = 1'b1;
        end
        if (ref_req_i != ref_want) begin
            ref_req_i = ref_want;
            changed   = 1'b1;
        end
        {act_gnt_i, rd_gnt_i, wr_gnt_i, pre_gnt_i, ref_gnt_i} = '0;
        lvl = level_kind();
        if (changed || hold_gnt || lvl == K_NONE) begin
            wait_kind = K_NONE;
        end else begin
            if (lvl != wait_kind) begin                 // new level, pick its delay
                wait_kind = lvl;
                wait_left = delay_tab[delay_idx % 256];
                delay_idx++;
            end
            if (wait_left == 0) begin
                drive_grant(lvl);
                wait_kind = K_NONE;
            end else begin
                wait_left--;
            end
        end
    end

    // bus monitor, logs every issued command
    always @(posedge clk) begin
        cmd_rec_t rec;
        if (rst_n) begin
            cycle++;
            rec       = '0;
            rec.kind  = issued_kind();
            rec.cmd   = cmd_o;
            rec.cyc   = cycle;
            rec.idle  = (rec.kind == K_PRE) && !req_valid_i;
            rec.ready = req_ready_o;
            if (rec.idle) begin
                model_open = 1'b0;                      // idle timer closed the row
                idle_cnt++;
            end
            if (ref_gnt_o !== (rec.kind == K_REF)) begin
                prot_errs++;
                $display("ref_gnt_o does not follow the refresh grant at cycle %0d", cycle);
            end
            if (rec.kind == K_REF) ref_cnt++;
            if (req_ready_o) begin
                if (!req_valid_i || !(rec.kind inside {K_RD, K_WR}) || req_done) begin
                    prot_errs++;
                    $display("ready pulse without a fresh accepted access at cycle %0d", cycle);
                end
                req_done = 1'b1;
                rdy_cnt++;
            end
            if (rec.kind != K_NONE) begin
                log_q.push_back(rec);
                -> logged;
            end
        end
    end

    // compares the log with the expected commands and the timing rules
    initial begin
        cmd_rec_t  rec;
        cmd_rec_t  exp;
        row_addr_t last_row;
        int        last_act;
        int        last_pre;
        int        last_ref;
        int        last_rd;
        int        last_wr;
        int        last_acc;
        last_row = '0;
        last_act = -100;
        last_pre = -100;
        last_ref = -100;
        last_rd  = -100;
        last_wr  = -100;
        last_acc = -100;
        forever begin
            @(logged);
            while (log_q.size() > 0) begin
                rec = log_q.pop_front();
                case (rec.kind)
                    K_ACT: begin
                        check_gap("act to act", last_act, rec.cyc, T_RC);
                        check_gap("pre to act", last_pre, rec.cyc, T_RP);
                        check_gap("refresh to act", last_ref, rec.cyc, T_RFC);
                        last_act = rec.cyc;
                    end
                    K_RD, K_WR: begin
                        check_gap("act to access", last_act, rec.cyc, T_RCD);
                        if (!rec.ready) begin
                            prot_errs++;
                            $display("access at cycle %0d gave no ready pulse", rec.cyc);
                        end
                        if (rec.kind == K_RD) last_rd = rec.cyc;
                        else last_wr = rec.cyc;
                        last_acc = rec.cyc;
                    end
                    K_PRE: begin
                        check_gap("act to pre", last_act, rec.cyc, T_RAS);
                        check_gap("write to pre", last_wr, rec.cyc, T_WTP);
                        check_gap("read to pre", last_rd, rec.cyc, T_RTP);
                        if (rec.idle) check_gap("access to idle close", last_acc, rec.cyc,
                                                T_ROW_IDLE);
                        last_pre = rec.cyc;
                    end
                    default: last_ref = rec.cyc;
                endcase
                if (rec.idle) begin
                    check_row("idle close row", last_row, rec.cmd.row);
                end else if (rec.kind != K_REF) begin
                    if (exp_q.size() == 0) begin
                        prot_errs++;
                        $display("command issued at cycle %0d with no request behind it",
                                 rec.cyc);
                    end else begin
                        exp = exp_q.pop_front();
                        check_kind("command kind", exp.kind, rec.kind);
                        check_cmd("command fields", exp.cmd, rec.cmd);
                        if (exp.kind inside {K_RD, K_WR}) last_row = exp.cmd.row;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("errors: value %0d, timing %0d, protocol %0d", val_errs, tim_errs, prot_errs);
        $display("watchdog: no finish after %0d cycles, the DUT seems to hang", TIMEOUT_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        cmd_kind_e k;
        bank_cmd_t c;
        void'($urandom(32'h77e1_77ae));
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        {act_gnt_i, rd_gnt_i, wr_gnt_i, pre_gnt_i, ref_gnt_i} = '0;
        ref_req_i   = 1'b0;
        req_done    = 1'b0;
        ref_want    = 1'b0;
        hold_gnt    = 1'b0;
        model_open  = 1'b0;
        model_row   = '0;
        wait_kind   = K_NONE;
        foreach (delay_tab[i]) begin
            delay_tab[i] = $urandom % 4;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (8) begin                                // quiet bus until traffic starts
            @(posedge clk);
            check_kind("quiet after reset", K_NONE, level_kind());
            if (req_ready_o || ref_gnt_o) begin
                prot_errs++;
                $display("ready or refresh grant high with nothing pending");
            end
        end
        for (int b = 0; b < BATCHES; b++) begin
            repeat (BATCH_LEN) begin
                req_q.push_back(random_request());
                sent++;
            end
            wait (rdy_cnt == sent);
            if (b % 2 == 1) wait (idle_cnt == (b + 1) / 2);  // idle timer closes the row
        end
        hold_gnt = 1'b1;                                // back-pressure
        req_q.push_back(random_request());
        sent++;
        do begin
            @(posedge clk);
        end while (level_kind() == K_NONE);
        k = level_kind();
        c = cmd_o;
        repeat (20) begin
            @(posedge clk);
            check_kind("stalled level", k, level_kind());
            check_cmd("stalled cmd", c, cmd_o);
            if (req_ready_o) begin
                prot_errs++;
                $display("ready pulse while all grants are held low");
            end
        end
        hold_gnt = 1'b0;
        wait (rdy_cnt == sent);
        ref_want = 1'b1;                                // served once the row closes
        wait (ref_cnt == 1);
        ref_want = 1'b0;
        repeat (2) begin
            req_q.push_back(random_request());
            sent++;
        end
        wait (rdy_cnt == sent);
        repeat (40) @(posedge clk);
        if (rdy_cnt != sent || exp_q.size() != 0 || ref_cnt != 1) begin
            prot_errs++;
            $display("run ended with unserved requests, missing commands or extra refreshes");
        end
        $display("errors: value %0d, timing %0d, protocol %0d", val_errs, tim_errs, prot_errs);
        if (val_errs + tim_errs + prot_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/bank_pkg.sv
design/bank_req_decode.sv
design/bank_timers.sv
design/bank_fsm.sv
design/bank_ctrl.sv
bench/bank_ctrl_tb.sv
